// ==== src/jtkcpu_pkg.sv ====
/*
    jtkcpu package
    Shared encodings for the reduced 8-bit core: instruction opcodes,
    sequencer states, ALU operations and condition code bit positions.
*/

package jtkcpu_pkg;

    // 6809-family opcodes kept in this core
    typedef enum logic [7:0] {
        op_suba_imm = 8'h80,
        op_anda_imm = 8'h84,
        op_lda_imm  = 8'h86,
        op_adda_imm = 8'h8B,
        op_lda_ext  = 8'hB6,
        op_sta_ext  = 8'hB7,
        op_bra      = 8'h20,
        op_bcs      = 8'h25,
        op_bne      = 8'h26,
        op_beq      = 8'h27,
        op_nop      = 8'h12
    } opcode_e;

    // sequencer steps, one per bus completion
    typedef enum logic [2:0] {
        st_fetch,
        st_opnd,
        st_ext_lo,
        st_access,
        st_exec
    } ctrl_state_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_pass
    } alu_op_e;

    // bit positions inside the 4-bit condition code
    localparam int cc_c = 0;
    localparam int cc_v = 1;
    localparam int cc_z = 2;
    localparam int cc_n = 3;

endpackage

// ==== src/jtkcpu_alu.sv ====
/*
    jtkcpu_alu
    Combinational 8-bit ALU: add, subtract, and, pass-through.
    Produces N, Z, V, C. Flags an operation leaves undefined are
    carried over from cc_in.
*/

`timescale 1ns/1ps

module jtkcpu_alu(
    input  jtkcpu_pkg::alu_op_e alu_op,
    input                 [7:0] a,
    input                 [7:0] b,
    input                 [3:0] cc_in,

    output logic          [7:0] rslt,
    output logic          [3:0] cc_out
);

import jtkcpu_pkg::*;

// bit 8 holds the carry or the borrow
logic [8:0] wide;

always_comb begin
    cc_out = cc_in;
    case (alu_op)
        alu_add: begin
            wide         = {1'b0, a} + {1'b0, b};
            cc_out[cc_v] = a[7] == b[7] && wide[7] != a[7];
            cc_out[cc_c] = wide[8];
        end
        alu_sub: begin
            wide         = {1'b0, a} - {1'b0, b};
            cc_out[cc_v] = a[7] != b[7] && wide[7] != a[7];
            cc_out[cc_c] = wide[8];
        end
        alu_and: begin
            wide         = {1'b0, a & b};
            cc_out[cc_v] = 1'b0;
        end
        default: begin
            wide         = {1'b0, b};
            cc_out[cc_v] = 1'b0;
        end
    endcase
    cc_out[cc_n] = wide[7];
    cc_out[cc_z] = wide[7:0] == 8'd0;
end

assign rslt = wide[7:0];

endmodule

// ==== src/jtkcpu_regs.sv ====
/*
    jtkcpu_regs
    Programmer-visible state: accumulator A, condition code and the
    program counter. Updates happen on bus completions only.
*/

`timescale 1ns/1ps

module jtkcpu_regs #(
    parameter logic [15:0] reset_pc = 16'h0000
)(
    input               clk,
    input               rst_n,
    input               cen,
    input               up_a,
    input               up_cc,
    input               up_pc,
    input               up_pc_rel,
    input        [ 7:0] rslt,
    input        [ 3:0] cc_out,
    input        [ 7:0] opnd,

    output logic [ 7:0] a,
    output logic [ 3:0] cc,
    output logic [15:0] pc
);

logic [15:0] offset;
logic [15:0] pc_inc;

// branch offset, sign extended
assign offset = {{8{opnd[7]}}, opnd};
assign pc_inc = pc + 16'd1;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        a  <= 8'd0;
        cc <= 4'd0;
        pc <= reset_pc;
    end else if (cen) begin
        if (up_a) begin
            a <= rslt;
        end
        if (up_cc) begin
            cc <= cc_out;
        end
        // taken branch is relative to the byte past the offset
        if (up_pc_rel) begin
            pc <= pc_inc + offset;
        end else if (up_pc) begin
            pc <= pc_inc;
        end
    end
end

endmodule

// ==== src/jtkcpu_memctrl.sv ====
/*
    jtkcpu_memctrl
    Memory side of the core. Latches the opcode and the two extended
    address bytes, selects the bus address between the program counter
    and the effective address, and drives the write strobe and data.
*/

`timescale 1ns/1ps

module jtkcpu_memctrl(
    input               clk,
    input               rst_n,
    input               cen,
    input        [ 7:0] din,
    input               fetch,
    input               opnd_hi,
    input               opnd_lo,
    input               addr_sel,
    input               wrq,
    input        [15:0] pc,
    input        [ 7:0] a,

    output logic [ 7:0] op,
    output logic [ 7:0] opnd,
    output logic [15:0] addr,
    output logic [ 7:0] dout,
    output logic        we
);

import jtkcpu_pkg::*;

logic [7:0] ea_hi, ea_lo;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        op <= op_nop;
    end else if (cen && fetch) begin
        op <= din;
    end
end

// extended address arrives high byte first
always_ff @(posedge clk) begin
    if (cen) begin
        if (opnd_hi) begin
            ea_hi <= din;
        end
        if (opnd_lo) begin
            ea_lo <= din;
        end
    end
end

// operand byte is valid on the completion edge of its access
assign opnd = din;

assign addr = addr_sel ? {ea_hi, ea_lo} : pc;
assign we   = wrq;
assign dout = wrq ? a : 8'h00;

endmodule

// ==== src/jtkcpu_ctrl.sv ====
/*
    jtkcpu_ctrl
    Instruction sequencer. Decodes the opcode on the bus during the fetch
    step, then walks the operand, extended address, data access and
    execute steps using the latched opcode. Drives the register update
    strobes, the ALU operation and the branch decision.
*/

`timescale 1ns/1ps

module jtkcpu_ctrl(
    input                        clk,
    input                        rst_n,
    input                        cen,
    input                        halt,
    input                  [7:0] op,
    input                  [7:0] din,
    input                  [3:0] cc,

    output logic                 fetch,
    output logic                 opnd_hi,
    output logic                 opnd_lo,
    output logic                 addr_sel,
    output logic                 wrq,
    output jtkcpu_pkg::alu_op_e  alu_op,
    output logic                 up_a,
    output logic                 up_cc,
    output logic                 up_pc,
    output logic                 up_pc_rel
);

import jtkcpu_pkg::*;

ctrl_state_e state, nx_state;
opcode_e     bus_op, cur_op;

assign bus_op = opcode_e'(din);
assign cur_op = opcode_e'(op);

// halt only holds off the start of a new instruction
assign fetch    = state == st_fetch && !halt;
assign opnd_hi  = state == st_opnd;
assign opnd_lo  = state == st_ext_lo;
assign addr_sel = state == st_access;
assign up_pc    = fetch || state == st_opnd || state == st_ext_lo || state == st_exec;

always_comb begin
    nx_state = state;
    case (state)
        st_fetch: begin
            if (!halt) begin
                case (bus_op)
                    op_lda_imm, op_adda_imm, op_suba_imm, op_anda_imm,
                    op_bra, op_beq, op_bne, op_bcs: nx_state = st_exec;
                    op_lda_ext, op_sta_ext:          nx_state = st_opnd;
                    // nop and anything unknown
                    default:                         nx_state = st_fetch;
                endcase
            end
        end
        st_opnd:   nx_state = st_ext_lo;
        st_ext_lo: nx_state = st_access;
        default:   nx_state = st_fetch;
    endcase
end

always_comb begin
    wrq       = 1'b0;
    alu_op    = alu_pass;
    up_a      = 1'b0;
    up_cc     = 1'b0;
    up_pc_rel = 1'b0;
    if (state == st_exec) begin
        case (cur_op)
            op_lda_imm: {up_a, up_cc} = 2'b11;
            op_adda_imm: begin
                alu_op        = alu_add;
                {up_a, up_cc} = 2'b11;
            end
            op_suba_imm: begin
                alu_op        = alu_sub;
                {up_a, up_cc} = 2'b11;
            end
            op_anda_imm: begin
                alu_op        = alu_and;
                {up_a, up_cc} = 2'b11;
            end
            // branch tests against the current flags
            op_bra:  up_pc_rel = 1'b1;
            op_beq:  up_pc_rel = cc[cc_z];
            op_bne:  up_pc_rel = !cc[cc_z];
            op_bcs:  up_pc_rel = cc[cc_c];
            default: up_pc_rel = 1'b0;
        endcase
    end else if (state == st_access) begin
        if (cur_op == op_sta_ext) begin
            wrq = 1'b1;
        end else begin
            {up_a, up_cc} = 2'b11;
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= st_fetch;
    end else if (cen) begin
        state <= nx_state;
    end
end

endmodule

// ==== src/jtkcpu.sv ====
/*
    jtkcpu
    Top level of the reduced 8-bit core. Builds the internal bus-cycle
    enable from cen2 and dtack and connects the sequencer, the memory
    controller, the ALU and the register file.
*/

`timescale 1ns/1ps

module jtkcpu #(
    parameter logic [15:0] reset_pc = 16'h0000
)(
    input               clk,
    input               rst_n,
    input               cen2,
    output              cen_out,
    input               halt,
    input               dtack,
    input        [ 7:0] din,
    output       [ 7:0] dout,
    output       [15:0] addr,
    output              we
);

import jtkcpu_pkg::*;

alu_op_e     alu_op;
logic [15:0] pc;
logic [ 7:0] op, opnd, rslt, a;
logic [ 3:0] cc, cc_out;
logic        fetch, opnd_hi, opnd_lo, addr_sel, wrq,
             up_a, up_cc, up_pc, up_pc_rel;
logic        phase, cen;

// every second qualified cycle completes a bus access
always_ff @(posedge clk) begin
    if (!rst_n) begin
        phase <= 1'b0;
    end else if (cen2 && dtack) begin
        phase <= ~phase;
    end
end

assign cen     = cen2 & dtack & phase;
assign cen_out = cen;

jtkcpu_ctrl u_ctrl(
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .cen       ( cen       ),
    .halt      ( halt      ),
    .op        ( op        ),
    .din       ( din       ),
    .cc        ( cc        ),
    .fetch     ( fetch     ),
    .opnd_hi   ( opnd_hi   ),
    .opnd_lo   ( opnd_lo   ),
    .addr_sel  ( addr_sel  ),
    .wrq       ( wrq       ),
    .alu_op    ( alu_op    ),
    .up_a      ( up_a      ),
    .up_cc     ( up_cc     ),
    .up_pc     ( up_pc     ),
    .up_pc_rel ( up_pc_rel )
);

jtkcpu_memctrl u_memctrl(
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .cen       ( cen       ),
    .din       ( din       ),
    .fetch     ( fetch     ),
    .opnd_hi   ( opnd_hi   ),
    .opnd_lo   ( opnd_lo   ),
    .addr_sel  ( addr_sel  ),
    .wrq       ( wrq       ),
    .pc        ( pc        ),
    .a         ( a         ),
    .op        ( op        ),
    .opnd      ( opnd      ),
    .addr      ( addr      ),
    .dout      ( dout      ),
    .we        ( we        )
);

jtkcpu_alu u_alu(
    .alu_op    ( alu_op    ),
    .a         ( a         ),
    .b         ( opnd      ),
    .cc_in     ( cc        ),
    .rslt      ( rslt      ),
    .cc_out    ( cc_out    )
);

jtkcpu_regs #(
    .reset_pc  ( reset_pc  )
) u_regs(
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .cen       ( cen       ),
    .up_a      ( up_a      ),
    .up_cc     ( up_cc     ),
    .up_pc     ( up_pc     ),
    .up_pc_rel ( up_pc_rel ),
    .rslt      ( rslt      ),
    .cc_out    ( cc_out    ),
    .opnd      ( opnd      ),
    .a         ( a         ),
    .cc        ( cc        ),
    .pc        ( pc        )
);

endmodule

// ==== dv/jtkcpu_sva.sv ====
/*
    jtkcpu_sva
    Bus assertions for the core: addr, we and dout only move after a
    completed access, and we stays low once reset has been applied.
*/

`timescale 1ns/1ps

module jtkcpu_sva(
    input        clk,
    input        rst_n,
    input        cen_out,
    input [15:0] addr,
    input [ 7:0] dout,
    input        we
);

// bus held between completions
bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !cen_out |=> $stable(addr) && $stable(we) && $stable(dout))
    else $error("bus changed without a completed access");

// no write request while in reset
no_write_in_reset: assert property (@(posedge clk)
    !rst_n |=> !we)
    else $error("we high during reset");

endmodule

bind jtkcpu jtkcpu_sva u_sva(
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen_out ( cen_out ),
    .addr    ( addr    ),
    .dout    ( dout    ),
    .we      ( we      )
);

// ==== dv/jtkcpu_tb.sv ====
/*
    jtkcpu_tb
    Random program testbench for the reduced core. Generates a program,
    serves it from a memory model with random dtack, cen2 and halt, and
    compares every bus write with an instruction-level model.
*/

`timescale 1ns/1ps

module jtkcpu_tb;

localparam int num_writes = 300;
localparam int wait_limit = 5000;

logic        clk = 1'b0;
logic        rst_n, cen2, dtack, halt;
logic [ 7:0] din, dout;
logic [15:0] addr;
logic        we, cen_out;

logic [ 7:0] mem  [0:65535];
logic [ 7:0] mmem [0:65535];
logic [31:0] seed = 32'h7c44_79ff;
logic [15:0] wr_addr_q[$];
logic [ 7:0] wr_data_q[$];
logic        first_seen = 1'b0;
logic [15:0] first_addr;
logic        first_we;

// model state
logic [15:0] m_pc;
logic [ 7:0] m_a;
logic        m_n, m_z, m_v, m_c;
logic        m_phase;

jtkcpu #(.reset_pc(16'h0000)) jtkcpu_inst(
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .cen2    ( cen2    ),
    .cen_out ( cen_out ),
    .halt    ( halt    ),
    .dtack   ( dtack   ),
    .din     ( din     ),
    .dout    ( dout    ),
    .addr    ( addr    ),
    .we      ( we      )
);

always #5 clk = ~clk;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic draw(output logic [31:0] r);
    seed = xorshift32(seed);
    r = seed;
endtask

// operand bytes never look like a branch or an extended opcode
function automatic logic [7:0] safe_operand(input logic [7:0] b);
    if (b[7:3] == 5'b00100 || b == 8'hB6 || b == 8'hB7) begin
        return b ^ 8'h40;
    end
    return b;
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("Checks failed");
        $fatal(1, "value mismatch");
    end
endtask

task automatic build_program();
    logic [31:0] r;
    int          p;
    for (int i = 0; i < 65536; i++) begin
        mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    end
    for (int i = 0; i < 32768; i++) begin
        mem[i] = 8'h12;
    end
    p = 0;
    // a backward branch lands on a BRA that jumps past it
    while (p < 16'h7FC0) begin
        draw(r);
        case (r[3:0])
            4'd0, 4'd1, 4'd2: mem[p] = 8'h86;
            4'd3:             mem[p] = 8'hB6;
            4'd4, 4'd5, 4'd6: mem[p] = 8'hB7;
            4'd7, 4'd15:      mem[p] = 8'h8B;
            4'd8:             mem[p] = 8'h80;
            4'd9:             mem[p] = 8'h84;
            4'd10:            mem[p] = 8'h20;
            4'd11:            mem[p] = 8'h27;
            4'd12:            mem[p] = 8'h26;
            4'd13:            mem[p] = 8'h25;
            default:          mem[p] = 8'h12;
        endcase
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd7, 4'd8, 4'd9, 4'd15: begin
                mem[p + 1] = safe_operand(r[15:8]);
                p += 2;
            end
            4'd3: begin
                mem[p + 1] = safe_operand(r[15:8]);
                mem[p + 2] = safe_operand(r[23:16]);
                p += 3;
            end
            4'd4, 4'd5, 4'd6: begin
                mem[p + 1] = safe_operand({1'b1, r[14:8]});
                mem[p + 2] = safe_operand(r[23:16]);
                p += 3;
            end
            4'd10, 4'd11, 4'd12, 4'd13: begin
                if (r[16]) begin
                    // bra +2, bra +2, then the branch with offset -4
                    mem[p + 4] = mem[p];
                    mem[p + 5] = 8'hFC;
                    mem[p]     = 8'h20;
                    mem[p + 1] = 8'h02;
                    mem[p + 2] = 8'h20;
                    mem[p + 3] = 8'h02;
                    p += 6;
                end else begin
                    mem[p + 1] = 8'(r[15:8] % 17);
                    p += 2;
                end
            end
            default: p += 1;
        endcase
    end
    for (int i = 0; i < 65536; i++) begin
        mmem[i] = mem[i];
    end
endtask

// run the model up to its next store
task automatic model_next_write(output logic [15:0] wa, output logic [7:0] wd);
    logic [7:0] opc, b;
    logic [8:0] wide;
    logic       done;
    int         steps;
    done  = 1'b0;
    steps = 0;
    while (!done) begin
        steps++;
        if (steps > 100000) begin
            $display("Checks failed");
            $fatal(1, "reference model ran too long without a store");
        end
        opc = mmem[m_pc];
        m_pc++;
        case (opc)
            8'h86, 8'h8B, 8'h80, 8'h84: begin
                b = mmem[m_pc];
                m_pc++;
                if (opc == 8'h86) begin
                    m_a = b;
                    m_v = 1'b0;
                end else if (opc == 8'h84) begin
                    m_a = m_a & b;
                    m_v = 1'b0;
                end else if (opc == 8'h8B) begin
                    wide = m_a + b;
                    m_v  = (m_a[7] == b[7]) && (wide[7] != m_a[7]);
                    m_c  = wide[8];
                    m_a  = wide[7:0];
                end else begin
                    wide = m_a - b;
                    m_v  = (m_a[7] != b[7]) && (wide[7] != m_a[7]);
                    m_c  = m_a < b;
                    m_a  = wide[7:0];
                end
                m_n = m_a[7];
                m_z = m_a == 8'd0;
            end
            8'hB6, 8'hB7: begin
                wa = {mmem[m_pc], mmem[m_pc + 16'd1]};
                m_pc += 16'd2;
                if (opc == 8'hB7) begin
                    wd       = m_a;
                    mmem[wa] = m_a;
                    done     = 1'b1;
                end else begin
                    m_a = mmem[wa];
                    m_n = m_a[7];
                    m_z = m_a == 8'd0;
                    m_v = 1'b0;
                end
            end
            8'h20, 8'h25, 8'h26, 8'h27: begin
                b = mmem[m_pc];
                m_pc++;
                if (opc == 8'h20 || (opc == 8'h27 && m_z) ||
                    (opc == 8'h26 && !m_z) || (opc == 8'h25 && m_c)) begin
                    m_pc = m_pc + {{8{b[7]}}, b};
                end
            end
            default: ;
        endcase
    end
endtask

// random bus handshakes and the memory read path
always @(posedge clk) begin
    logic [31:0] r;
    draw(r);
    cen2  <= r[1:0] != 2'd0;
    dtack <= r[3:2] != 2'd0;
    if (halt) begin
        halt <= r[6:4] != 3'd0;
    end else begin
        halt <= r[11:4] == 8'd0;
    end
    din <= mem[addr];
end

// a completion falls on every second cycle with cen2 and dtack high
always @(posedge clk) begin
    if (!rst_n) begin
        m_phase <= 1'b0;
    end else begin
        compare("cen_out", cen_out, cen2 && dtack && m_phase);
        if (cen2 && dtack) begin
            m_phase <= !m_phase;
        end
    end
end

// completed accesses
always @(posedge clk) begin
    if (rst_n && cen_out) begin
        if (!first_seen) begin
            first_seen <= 1'b1;
            first_addr <= addr;
            first_we   <= we;
        end
        if (we) begin
            mem[addr] <= dout;
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(dout);
        end
    end
end

initial begin
    logic [15:0] exp_addr, got_addr;
    logic [ 7:0] exp_data, got_data;
    int          cycles;
    rst_n = 1'b0;
    cen2  = 1'b0;
    dtack = 1'b0;
    halt  = 1'b0;
    din   = 8'h00;
    m_pc  = 16'h0000;
    m_a   = 8'h00;
    {m_n, m_z, m_v, m_c} = 4'b0000;
    build_program();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    cycles = 0;
    while (!first_seen) begin
        @(posedge clk);
        cycles++;
        if (cycles > wait_limit) begin
            $display("Checks failed");
            $fatal(1, "no bus access completed after reset");
        end
    end
    compare("addr", first_addr, 16'h0000);
    compare("we", first_we, 1'b0);

    for (int n = 0; n < num_writes; n++) begin
        cycles = 0;
        while (wr_addr_q.size() == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("Checks failed");
                $fatal(1, "timed out waiting for write number %0d", n);
            end
        end
        got_addr = wr_addr_q.pop_front();
        got_data = wr_data_q.pop_front();
        model_next_write(exp_addr, exp_data);
        compare("addr", got_addr, exp_addr);
        compare("dout", got_data, exp_data);
    end

    $display("All checks passed");
    $finish;
end

endmodule

// ==== compile.f ====
src/jtkcpu_pkg.sv
src/jtkcpu_alu.sv
src/jtkcpu_regs.sv
src/jtkcpu_memctrl.sv
src/jtkcpu_ctrl.sv
src/jtkcpu.sv
dv/jtkcpu_sva.sv
dv/jtkcpu_tb.sv

// ==== Makefile ====
# Verilator build for the jtkcpu testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= jtkcpu_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
